// File: Makefile
# Verilator build and run of the flash fetch testbench

SRCS := $(filter-out +%,$(shell cat compile.f)) hdl/flash_params.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vflash_fetch_tb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module flash_fetch_tb \
		-f compile.f -o Vflash_fetch_tb

run: obj_dir/Vflash_fetch_tb
	obj_dir/Vflash_fetch_tb +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q '^No errors$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/spi_pkg.sv
hdl/spi_flash_reader.sv
hdl/bus_arb.sv
hdl/dbus_flash_window.sv
hdl/flash_fetch_top.sv
verification/spi_flash_model.sv
verification/flash_fetch_asserts.sv
verification/flash_fetch_tb.sv

// File: hdl/bus_arb.sv
`timescale 1ns/1ps

module bus_arb (
    input  logic         ck,
    input  logic         reset_loop,
    input  logic         a_cyc,
    input  wb_pkg::adr_t a_adr,
    output logic         a_ack,
    output wb_pkg::dat_t a_rdt,
    input  logic         b_cyc,
    input  wb_pkg::adr_t b_adr,
    output logic         b_ack,
    output wb_pkg::dat_t b_rdt,
    output logic         x_cyc,
    output wb_pkg::adr_t x_adr,
    input  logic         x_ack,
    input  wb_pkg::dat_t x_rdt
);

    wb_pkg::grant_t grant;
    wb_pkg::grant_t owner;

    // New grant taken in the same cycle when idle, port a wins ties
    always_comb begin
        owner = grant;
        if (grant == wb_pkg::GRANT_NONE) begin
            if (a_cyc) begin
                owner = wb_pkg::GRANT_A;
            end else if (b_cyc) begin
                owner = wb_pkg::GRANT_B;
            end
        end
    end

    always_comb begin
        case (owner)
            wb_pkg::GRANT_A: begin
                x_cyc = a_cyc;
                x_adr = a_adr;
            end
            wb_pkg::GRANT_B: begin
                x_cyc = b_cyc;
                x_adr = b_adr;
            end
            default: begin
                x_cyc = 1'b0;
                x_adr = '0;
            end
        endcase
    end

    // Only the owner sees the ack and the word
    assign a_ack = x_ack && (owner == wb_pkg::GRANT_A);
    assign b_ack = x_ack && (owner == wb_pkg::GRANT_B);
    assign a_rdt = a_ack ? x_rdt : '0;
    assign b_rdt = b_ack ? x_rdt : '0;

    always_ff @(posedge ck) begin
        if (reset_loop) begin
            grant <= wb_pkg::GRANT_NONE;
        end else if (x_ack) begin
            grant <= wb_pkg::GRANT_NONE;
        end else begin
            grant <= owner;
        end
    end

endmodule

// File: hdl/dbus_flash_window.sv
`timescale 1ns/1ps

`include "flash_params.svh"

module dbus_flash_window (
    input  logic         ck,
    input  logic         reset_loop,
    input  logic         dbus_cyc,
    input  logic         dbus_we,
    input  wb_pkg::adr_t dbus_adr,
    output logic         dbus_ack,
    output wb_pkg::dat_t dbus_rdt,
    output logic         f_cyc,
    output wb_pkg::adr_t f_adr,
    input  logic         f_ack,
    input  wb_pkg::dat_t f_rdt
);

    logic win_hit;
    logic rd_hit;
    logic wr_hit;
    logic wr_ack;

    // Window selected by the top address byte
    assign win_hit = (dbus_adr[31:24] == `FLASH_WIN_TOP);
    assign rd_hit  = dbus_cyc && win_hit && !dbus_we;
    assign wr_hit  = dbus_cyc && win_hit && dbus_we;

    // Reads go on to the arbiter
    assign f_cyc = rd_hit;
    assign f_adr = rd_hit ? dbus_adr : '0;

    // Flash is read only here, writes are simply acked
    always_ff @(posedge ck) begin
        if (reset_loop) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= wr_hit && !wr_ack;
        end
    end

    // Zero outside the window so the board can OR other slaves in
    assign dbus_ack = wr_ack || (f_ack && rd_hit);
    assign dbus_rdt = rd_hit ? f_rdt : '0;

endmodule

// File: hdl/flash_fetch_top.sv
`timescale 1ns/1ps

module flash_fetch_top (
    input  logic         ck,
    input  logic         reset_loop,
    input  logic         ibus_cyc,
    input  wb_pkg::adr_t ibus_adr,
    output logic         ibus_ack,
    output wb_pkg::dat_t ibus_rdt,
    input  logic         dbus_cyc,
    input  logic         dbus_we,
    input  wb_pkg::adr_t dbus_adr,
    output logic         dbus_ack,
    output wb_pkg::dat_t dbus_rdt,
    output logic         spi_cs,
    output logic         spi_sck,
    output logic         spi_mosi,
    input  logic         spi_miso
);

    // Window to arbiter port b
    logic         f_cyc;
    wb_pkg::adr_t f_adr;
    logic         f_ack;
    wb_pkg::dat_t f_rdt;

    // Arbiter to flash reader
    logic         x_cyc;
    wb_pkg::adr_t x_adr;
    logic         x_ack;
    wb_pkg::dat_t x_rdt;

    dbus_flash_window u_window (
        .ck         (ck),
        .reset_loop (reset_loop),
        .dbus_cyc   (dbus_cyc),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_ack   (dbus_ack),
        .dbus_rdt   (dbus_rdt),
        .f_cyc      (f_cyc),
        .f_adr      (f_adr),
        .f_ack      (f_ack),
        .f_rdt      (f_rdt)
    );

    // Instruction bus has priority on port a
    bus_arb u_arb (
        .ck         (ck),
        .reset_loop (reset_loop),
        .a_cyc      (ibus_cyc),
        .a_adr      (ibus_adr),
        .a_ack      (ibus_ack),
        .a_rdt      (ibus_rdt),
        .b_cyc      (f_cyc),
        .b_adr      (f_adr),
        .b_ack      (f_ack),
        .b_rdt      (f_rdt),
        .x_cyc      (x_cyc),
        .x_adr      (x_adr),
        .x_ack      (x_ack),
        .x_rdt      (x_rdt)
    );

    spi_flash_reader u_reader (
        .ck         (ck),
        .reset_loop (reset_loop),
        .cyc        (x_cyc),
        .adr        (x_adr),
        .ack        (x_ack),
        .rdt        (x_rdt),
        .spi_cs     (spi_cs),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

endmodule

// File: hdl/flash_params.svh
`ifndef FLASH_PARAMS_SVH
`define FLASH_PARAMS_SVH

// Address bits sent to the flash after the opcode
`define FLASH_ADR_BITS 24

// Top data-bus address byte that selects the flash window
`define FLASH_WIN_TOP 8'h70

// ck cycles per SPI clock period, one low half and one high half
`define SPI_CK_DIV 2

`endif

// File: hdl/spi_flash_reader.sv
`timescale 1ns/1ps

`include "flash_params.svh"

module spi_flash_reader (
    input  logic          ck,
    input  logic          reset_loop,
    input  logic          cyc,
    input  wb_pkg::adr_t  adr,
    output logic          ack,
    output wb_pkg::dat_t  rdt,
    output logic          spi_cs,
    output logic          spi_sck,
    output logic          spi_mosi,
    input  logic          spi_miso
);

    localparam int CMD_BITS = 8;
    localparam int ADR_BITS = `FLASH_ADR_BITS;
    localparam int OUT_BITS = CMD_BITS + ADR_BITS;
    localparam int DAT_BITS = $bits(wb_pkg::dat_t);
    localparam int HALF     = `SPI_CK_DIV / 2;
    localparam int DIV_W    = $clog2(`SPI_CK_DIV);

    spi_pkg::reader_state_t state;

    logic [OUT_BITS-1:0] sh_out;
    logic [DAT_BITS-1:0] sh_in;
    logic [5:0]          bit_cnt;
    logic [DIV_W-1:0]    div_cnt;
    logic                shifting;
    logic                rise;
    logic                period_end;
    logic                bit_last;

    assign shifting = (state == spi_pkg::RD_CMD) || (state == spi_pkg::RD_ADR) ||
                      (state == spi_pkg::RD_DATA);

    // Last ck of the low half, sck goes high on this edge
    assign rise       = (div_cnt == DIV_W'(HALF - 1));
    assign period_end = (div_cnt == DIV_W'(`SPI_CK_DIV - 1));

    // Last bit of the current phase
    always_comb begin
        case (state)
            spi_pkg::RD_CMD: bit_last = (bit_cnt == 6'(CMD_BITS - 1));
            spi_pkg::RD_ADR: bit_last = (bit_cnt == 6'(ADR_BITS - 1));
            default:         bit_last = (bit_cnt == 6'(DAT_BITS - 1));
        endcase
    end

    always_ff @(posedge ck) begin
        if (reset_loop) begin
            state    <= spi_pkg::RD_IDLE;
            spi_cs   <= 1'b1;
            spi_sck  <= 1'b0;
            spi_mosi <= 1'b0;
            ack      <= 1'b0;
            bit_cnt  <= '0;
            div_cnt  <= '0;
        end else begin
            ack <= 1'b0;
            case (state)
                spi_pkg::RD_IDLE: begin
                    if (cyc) begin
                        state <= spi_pkg::RD_SELECT;
                    end
                end
                spi_pkg::RD_SELECT: begin
                    // Chip select low, first opcode bit on mosi
                    spi_cs   <= 1'b0;
                    spi_mosi <= sh_out[OUT_BITS-1];
                    bit_cnt  <= '0;
                    div_cnt  <= '0;
                    state    <= spi_pkg::RD_CMD;
                end
                spi_pkg::RD_CMD, spi_pkg::RD_ADR, spi_pkg::RD_DATA: begin
                    div_cnt <= period_end ? '0 : div_cnt + 1'b1;
                    if (rise) begin
                        spi_sck <= 1'b1;
                    end
                    if (period_end) begin
                        // Falling sck, next bit goes out
                        spi_sck  <= 1'b0;
                        spi_mosi <= sh_out[OUT_BITS-1];
                        if (bit_last) begin
                            bit_cnt <= '0;
                            case (state)
                                spi_pkg::RD_CMD: state <= spi_pkg::RD_ADR;
                                spi_pkg::RD_ADR: state <= spi_pkg::RD_DATA;
                                default: begin
                                    spi_cs <= 1'b1;
                                    ack    <= 1'b1;
                                    state  <= spi_pkg::RD_RELEASE;
                                end
                            endcase
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                spi_pkg::RD_RELEASE: begin
                    // Ack cycle, cyc still held by the requester
                    state <= spi_pkg::RD_IDLE;
                end
                default: begin
                    state <= spi_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // Shift registers and the returned word
    always_ff @(posedge ck) begin
        if (state == spi_pkg::RD_IDLE && cyc) begin
            // Word aligned, low address bits only
            sh_out <= {spi_pkg::FLASH_CMD_READ, adr[ADR_BITS-1:2], 2'b00};
        end else if (state == spi_pkg::RD_SELECT || (shifting && period_end)) begin
            sh_out <= sh_out << 1;
        end
        if (state == spi_pkg::RD_DATA && rise) begin
            sh_in <= {sh_in[DAT_BITS-2:0], spi_miso};
        end
        if (state == spi_pkg::RD_DATA && period_end && bit_last) begin
            // First byte received lands in bits 7:0
            rdt <= {sh_in[7:0], sh_in[15:8], sh_in[23:16], sh_in[31:24]};
        end
    end

endmodule

// File: hdl/spi_pkg.sv
package spi_pkg;

    // Standard single-lane read, sent msb first
    localparam logic [7:0] FLASH_CMD_READ = 8'h03;

    // Phases of one word read
    typedef enum logic [2:0] {
        RD_IDLE    = 3'd0,
        RD_SELECT  = 3'd1,
        RD_CMD     = 3'd2,
        RD_ADR     = 3'd3,
        RD_DATA    = 3'd4,
        RD_RELEASE = 3'd5
    } reader_state_t;

endpackage

// File: hdl/wb_pkg.sv
package wb_pkg;

    // Byte address on either bus
    typedef logic [31:0] adr_t;

    // One bus data word
    typedef logic [31:0] dat_t;

    // Current owner of the shared flash reader
    typedef enum logic [1:0] {
        GRANT_NONE = 2'd0,
        GRANT_A    = 2'd1,
        GRANT_B    = 2'd2
    } grant_t;

endpackage

// File: verification/flash_fetch_asserts.sv
`timescale 1ns/1ps

module flash_fetch_asserts (
    input logic ck,
    input logic reset_loop,
    input logic ibus_cyc,
    input logic ibus_ack,
    input logic dbus_cyc,
    input logic dbus_ack,
    input logic spi_cs,
    input logic spi_sck
);

    logic sck_fail  = 1'b0;
    logic ibus_fail = 1'b0;
    logic dbus_fail = 1'b0;
    logic any_fail;

    assign any_fail = sck_fail || ibus_fail || dbus_fail;

    // SPI clock parked low while the flash is deselected
    sck_parked: assert property (@(posedge ck) disable iff (reset_loop)
        spi_cs |-> !spi_sck)
    else begin
        sck_fail = 1'b1;
        $error("spi_sck is high while spi_cs is high");
    end

    // Ack only inside a cycle, and for one clock
    ibus_ack_pulse: assert property (@(posedge ck) disable iff (reset_loop)
        ibus_ack |-> ibus_cyc ##1 !ibus_ack)
    else begin
        ibus_fail = 1'b1;
        $error("ibus_ack without ibus_cyc or longer than one cycle");
    end

    dbus_ack_pulse: assert property (@(posedge ck) disable iff (reset_loop)
        dbus_ack |-> dbus_cyc ##1 !dbus_ack)
    else begin
        dbus_fail = 1'b1;
        $error("dbus_ack without dbus_cyc or longer than one cycle");
    end

endmodule

bind flash_fetch_top flash_fetch_asserts u_asserts (
    .ck         (ck),
    .reset_loop (reset_loop),
    .ibus_cyc   (ibus_cyc),
    .ibus_ack   (ibus_ack),
    .dbus_cyc   (dbus_cyc),
    .dbus_ack   (dbus_ack),
    .spi_cs     (spi_cs),
    .spi_sck    (spi_sck)
);

// File: verification/flash_fetch_tb.sv
`timescale 1ns/1ps

`include "flash_params.svh"

module flash_fetch_tb;

    localparam int ACK_TIMEOUT  = 400;
    // Longer than one complete flash read
    localparam int QUIET_CYCLES = 300;

    logic         ck;
    logic         reset_loop;
    logic         ibus_cyc;
    wb_pkg::adr_t ibus_adr;
    logic         ibus_ack;
    wb_pkg::dat_t ibus_rdt;
    logic         dbus_cyc;
    logic         dbus_we;
    wb_pkg::adr_t dbus_adr;
    logic         dbus_ack;
    wb_pkg::dat_t dbus_rdt;
    logic         spi_cs;
    logic         spi_sck;
    logic         spi_mosi;
    logic         spi_miso;
    int unsigned  seed_draw;

    flash_fetch_top UUT (
        .ck         (ck),
        .reset_loop (reset_loop),
        .ibus_cyc   (ibus_cyc),
        .ibus_adr   (ibus_adr),
        .ibus_ack   (ibus_ack),
        .ibus_rdt   (ibus_rdt),
        .dbus_cyc   (dbus_cyc),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_ack   (dbus_ack),
        .dbus_rdt   (dbus_rdt),
        .spi_cs     (spi_cs),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

    spi_flash_model u_flash (
        .spi_cs   (spi_cs),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    always #2 ck = ~ck;

    always @(negedge ck) begin
        if (UUT.u_asserts.any_fail) begin
            $display("A bound check on the SPI pins or the bus acks failed");
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Inputs change 1 ns after the rising edge, outputs are read there too
    task automatic next_cycle();
        @(posedge ck);
        #1;
    endtask

    task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] got);
        assert (got == exp) else begin
            $display("Fail %s: expected %h, got %h", test, exp, got);
            stop_with_failure();
        end
    endtask

    // Address the flash model took from spi_mosi in the last read
    task automatic check_flash_adr(input string test, input wb_pkg::adr_t adr);
        check_value(test, {8'h00, adr[23:2], 2'b00}, {8'h00, u_flash.adr});
    endtask

    function automatic logic [7:0] rule_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // First flash byte in bits 7:0
    function automatic wb_pkg::dat_t expected_word(input wb_pkg::adr_t adr);
        logic [23:0] base;
        base = {adr[23:2], 2'b00};
        return {rule_byte(base + 24'd3), rule_byte(base + 24'd2),
                rule_byte(base + 24'd1), rule_byte(base)};
    endfunction

    task automatic fetch_word(input wb_pkg::adr_t adr, output wb_pkg::dat_t rdt);
        int cycles;
        cycles   = 0;
        ibus_adr = adr;
        ibus_cyc = 1'b1;
        next_cycle();
        while (!ibus_ack && cycles < ACK_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!ibus_ack) begin
            $display("Instruction fetch at %h was never acked", adr);
            stop_with_failure();
        end
        rdt = ibus_rdt;
        // Ack is taken at the next edge, then cyc drops
        next_cycle();
        ibus_cyc = 1'b0;
    endtask

    task automatic window_access(input logic we, input wb_pkg::adr_t adr,
                                 output wb_pkg::dat_t rdt, output int cycles);
        cycles   = 0;
        dbus_adr = adr;
        dbus_we  = we;
        dbus_cyc = 1'b1;
        next_cycle();
        while (!dbus_ack && cycles < ACK_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!dbus_ack) begin
            $display("Data bus access at %h was never acked", adr);
            stop_with_failure();
        end
        rdt = dbus_rdt;
        next_cycle();
        dbus_cyc = 1'b0;
        dbus_we  = 1'b0;
    endtask

    task automatic test_reset();
        check_value("reset spi_cs", 32'd1, 32'(spi_cs));
        check_value("reset spi_sck", 32'd0, 32'(spi_sck));
        check_value("reset ibus_ack", 32'd0, 32'(ibus_ack));
        check_value("reset dbus_ack", 32'd0, 32'(dbus_ack));
    endtask

    task automatic test_fetch();
        wb_pkg::adr_t adr;
        wb_pkg::dat_t got;
        adr = $urandom & ~32'h3;
        fetch_word(adr, got);
        check_value("instruction fetch", expected_word(adr), got);
        check_flash_adr("instruction fetch address", adr);
    endtask

    task automatic test_window_read();
        wb_pkg::adr_t adr;
        wb_pkg::dat_t got;
        int cycles;
        int i;
        adr = {`FLASH_WIN_TOP, 24'($urandom)};
        window_access(1'b0, adr, got, cycles);
        check_value("window read", expected_word(adr), got);
        check_flash_adr("window read address", adr);
        // Outside the window nothing answers and the flash stays idle
        adr      = {8'h20, 24'($urandom)};
        dbus_adr = adr;
        dbus_we  = 1'b0;
        dbus_cyc = 1'b1;
        for (i = 0; i < QUIET_CYCLES; i++) begin
            next_cycle();
            assert (!dbus_ack && dbus_rdt == '0 && spi_cs) else begin
                $display("Read outside the window at %h got a response", adr);
                stop_with_failure();
            end
        end
        dbus_cyc = 1'b0;
    endtask

    task automatic test_window_write();
        wb_pkg::adr_t adr;
        wb_pkg::dat_t got;
        int cycles;
        adr = {`FLASH_WIN_TOP, 24'($urandom)} & ~32'h3;
        window_access(1'b1, adr, got, cycles);
        check_value("window write wait cycles", 32'd0, 32'(cycles));
        fetch_word(adr, got);
        check_value("fetch after write", expected_word(adr), got);
        check_flash_adr("fetch after write address", adr);
    endtask

    task automatic test_same_cycle();
        wb_pkg::adr_t i_adr;
        wb_pkg::adr_t d_adr;
        bit i_done;
        bit d_done;
        int i_at;
        int d_at;
        int cycles;
        i_adr    = $urandom & ~32'h3;
        d_adr    = {`FLASH_WIN_TOP, 24'($urandom)};
        i_done   = 1'b0;
        d_done   = 1'b0;
        i_at     = 0;
        d_at     = 0;
        cycles   = 0;
        ibus_adr = i_adr;
        ibus_cyc = 1'b1;
        dbus_adr = d_adr;
        dbus_we  = 1'b0;
        dbus_cyc = 1'b1;
        while (!(i_done && d_done) && cycles < 2 * ACK_TIMEOUT) begin
            next_cycle();
            cycles++;
            // Each requester drops cyc one cycle after its ack
            if (i_done) ibus_cyc = 1'b0;
            if (d_done) dbus_cyc = 1'b0;
            if (ibus_ack && !i_done) begin
                check_value("same cycle ifetch", expected_word(i_adr), ibus_rdt);
                check_flash_adr("same cycle ifetch address", i_adr);
                i_done = 1'b1;
                i_at   = cycles;
            end
            if (dbus_ack && !d_done) begin
                check_value("same cycle window read", expected_word(d_adr), dbus_rdt);
                check_flash_adr("same cycle window read address", d_adr);
                d_done = 1'b1;
                d_at   = cycles;
            end
        end
        if (!(i_done && d_done)) begin
            $display("Requests raised in the same cycle were not both acked");
            stop_with_failure();
        end
        next_cycle();
        ibus_cyc = 1'b0;
        dbus_cyc = 1'b0;
        assert (i_at < d_at) else begin
            $display("Data bus read was acked before the instruction fetch");
            stop_with_failure();
        end
    endtask

    task automatic test_mixed();
        wb_pkg::adr_t adr;
        wb_pkg::dat_t got;
        int cycles;
        int i;
        for (i = 0; i < 10; i++) begin
            adr = $urandom & ~32'h3;
            fetch_word(adr, got);
            check_value("mixed fetch", expected_word(adr), got);
            check_flash_adr("mixed fetch address", adr);
            if (($urandom % 2) == 1) begin
                adr = {`FLASH_WIN_TOP, 24'($urandom)};
                window_access(1'b0, adr, got, cycles);
                check_value("mixed window read", expected_word(adr), got);
                check_flash_adr("mixed window read address", adr);
            end
        end
    endtask

    initial begin
        ck         = 1'b0;
        reset_loop = 1'b1;
        ibus_cyc   = 1'b0;
        ibus_adr   = '0;
        dbus_cyc   = 1'b0;
        dbus_we    = 1'b0;
        dbus_adr   = '0;
        seed_draw  = $urandom(32'h5e54);
        repeat (5) @(posedge ck);
        #1;
        reset_loop = 1'b0;
        test_reset();
        test_fetch();
        test_window_read();
        test_window_write();
        test_same_cycle();
        test_mixed();
        next_cycle();
        if (UUT.u_asserts.any_fail) begin
            $display("Errors found");
        end else begin
            $display("No errors");
        end
        $finish;
    end

endmodule

// File: verification/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model (
    input  logic spi_cs,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic spi_miso
);

    logic [7:0]  opcode   = '0;
    logic [23:0] adr      = '0;
    int unsigned bit_cnt  = 0;
    logic        miso_q   = 1'b0;
    logic [4:0]  out_idx;
    logic [7:0]  out_byte;

    assign spi_miso = miso_q;

    // Flash contents for one byte address
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // Opcode then address, msb first on rising sck
    always @(posedge spi_sck or posedge spi_cs) begin
        if (spi_cs) begin
            bit_cnt <= 0;
        end else begin
            if (bit_cnt < 8) begin
                opcode <= {opcode[6:0], spi_mosi};
            end else if (bit_cnt < 32) begin
                adr <= {adr[22:0], spi_mosi};
            end
            bit_cnt <= bit_cnt + 1;
        end
    end

    // Data goes out on falling sck, bytes at rising addresses
    always @(negedge spi_sck) begin
        if (!spi_cs && opcode == spi_pkg::FLASH_CMD_READ && bit_cnt >= 32 && bit_cnt < 64) begin
            out_idx  = 5'(bit_cnt - 32);
            out_byte = byte_at(adr + {22'b0, out_idx[4:3]});
            // msb of each byte first
            miso_q <= out_byte[~out_idx[2:0]];
        end
    end

endmodule
